/* include/tama_settings.svh */
/*
  Shared constants for the handheld-emulation glue logic.
  Bridge addresses, divider reload counts and program memory sizes.
  Included by the RTL and by the testbench model.
*/

`ifndef TAMA_SETTINGS_SVH
`define TAMA_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// bridge register map

`define TAMA_ADDR_SOUND   32'h0000_0010
`define TAMA_ADDR_TURBO   32'h0000_0100
`define TAMA_ADDR_CANCEL  32'h0000_0104

// upper address nibble of the program download window
`define TAMA_ROM_WINDOW   4'h1

//////////////////////////////////////////////////////////////////////
// divider reload counts per turbo speed

`define TAMA_RELOAD_1X    400
`define TAMA_RELOAD_4X    100
`define TAMA_RELOAD_50X   8
// max speed runs at the 50x rate for now
`define TAMA_RELOAD_MAX   8

//////////////////////////////////////////////////////////////////////
// memory and audio sizes

`define TAMA_ROM_DEPTH    8192
`define TAMA_BUZZER_BITS  13
// minimum cycles between two ROM window writes
`define TAMA_LOADER_GAP   3

`endif

/* hdl/tama_pkg.sv */
/*
  Types shared by the glue logic modules and the testbench.
  Referenced by scoped name from each file that needs them.
*/

package tama_pkg;

  // bridge address and data
  typedef logic [31:0] bridge_word_t;

  // turbo speed setting, encoded as the bridge writes it
  typedef enum logic [1:0] {
    speed_1x  = 2'd0,
    speed_4x  = 2'd1,
    speed_50x = 2'd2,
    speed_max = 2'd3
  } turbo_speed_t;

  // program memory word address, byte address bits 13:1
  typedef logic [12:0] rom_addr_t;

  // stored program word
  typedef logic [15:0] rom_word_t;

  // fetch data seen by the CPU
  typedef logic [11:0] fetch_data_t;

  // divider down-counter
  typedef logic [9:0] div_count_t;

  // audio level to the serializer
  typedef logic [14:0] audio_sample_t;

endpackage

/* hdl/bridge_settings.sv */
/*
  Host-visible settings registers: sound disable, turbo speed and
  cancel turbo on event. Writes land one cycle after the strobe,
  the turbo speed reads back combinationally.
*/

`timescale 1ns/10ps

`include "tama_settings.svh"

module bridge_settings (
  input  logic                   clk_32_768,
  input  logic                   reset_turbo_s,
  input  tama_pkg::bridge_word_t bridge_addr,
  input  logic                   bridge_wr,
  input  tama_pkg::bridge_word_t bridge_wr_data,
  input  logic                   cancel_pulse,
  output tama_pkg::bridge_word_t bridge_rd_data,
  output tama_pkg::turbo_speed_t turbo_speed,
  output logic                   disable_sound,
  output logic                   cancel_on_event
);

  //////////////////////////////////////////////////////////////////////
  // write decode

  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      disable_sound   <= 1'b0;
      turbo_speed     <= tama_pkg::speed_1x;
      cancel_on_event <= 1'b0;
    end else begin
      if (bridge_wr) begin
        case (bridge_addr)
          `TAMA_ADDR_SOUND: begin
            disable_sound <= bridge_wr_data[0];
          end
          `TAMA_ADDR_TURBO: begin
            turbo_speed <= tama_pkg::turbo_speed_t'(bridge_wr_data[1:0]);
          end
          `TAMA_ADDR_CANCEL: begin
            cancel_on_event <= bridge_wr_data[0];
          end
          default: ;
        endcase
      end
      // buzzer event drops back to 1x, even over a host write
      if (cancel_pulse) begin
        turbo_speed <= tama_pkg::speed_1x;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux

  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr == `TAMA_ADDR_TURBO) begin
      bridge_rd_data = {30'b0, turbo_speed};
    end
  end

  // a cancel from the buzzer side always lands at 1x
  cancel_to_1x_a : assert property (
    @(posedge clk_32_768) disable iff (reset_turbo_s)
    cancel_pulse |=> (turbo_speed == tama_pkg::speed_1x)
  );

endmodule

/* hdl/turbo_clock_divider.sv */
/*
  CPU clock enable generator. A reloading down-counter gives clk_en
  once per period and clk_2x_en twice, the period set by turbo speed.
  A new speed is picked up at the next reload.
*/

`timescale 1ns/10ps

`include "tama_settings.svh"

module turbo_clock_divider (
  input  logic                   clk_32_768,
  input  logic                   reset_turbo_s,
  input  tama_pkg::turbo_speed_t turbo_speed,
  output logic                   clk_en,
  output logic                   clk_2x_en
);

  tama_pkg::div_count_t reload_value;
  tama_pkg::div_count_t count;

  // speed to reload count
  always_comb begin
    case (turbo_speed)
      tama_pkg::speed_4x:  reload_value = tama_pkg::div_count_t'(`TAMA_RELOAD_4X);
      tama_pkg::speed_50x: reload_value = tama_pkg::div_count_t'(`TAMA_RELOAD_50X);
      tama_pkg::speed_max: reload_value = tama_pkg::div_count_t'(`TAMA_RELOAD_MAX);
      default:             reload_value = tama_pkg::div_count_t'(`TAMA_RELOAD_1X);
    endcase
  end

  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      count     <= tama_pkg::div_count_t'(`TAMA_RELOAD_1X);
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
    end else begin
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
      if (count == '0) begin
        count     <= reload_value;
        clk_en    <= 1'b1;
        clk_2x_en <= 1'b1;
      end else begin
        count <= count - tama_pkg::div_count_t'(1);
        // second edge half way through the period
        if (count == (reload_value >> 1)) begin
          clk_2x_en <= 1'b1;
        end
      end
    end
  end

  // the CPU expects both edges on a full-rate tick
  en_with_2x_a : assert property (
    @(posedge clk_32_768) disable iff (reset_turbo_s)
    $rose(clk_en) |-> clk_2x_en
  );

endmodule

/* hdl/bridge_word_loader.sv */
/*
  Splits 32-bit bridge writes in the ROM window into two 16-bit
  program word writes, high half first at byte address A, then the
  low half at A+2, on the two cycles after the bridge strobe.
*/

`timescale 1ns/10ps

`include "tama_settings.svh"

module bridge_word_loader (
  input  logic                   clk_32_768,
  input  logic                   reset_turbo_s,
  input  tama_pkg::bridge_word_t bridge_addr,
  input  logic                   bridge_wr,
  input  tama_pkg::bridge_word_t bridge_wr_data,
  output logic                   word_wr,
  output tama_pkg::rom_addr_t    word_addr,
  output tama_pkg::rom_word_t    word_data
);

  logic                rom_hit;
  logic                low_pending;
  tama_pkg::rom_word_t low_half;

  assign rom_hit = bridge_wr && (bridge_addr[31:28] == `TAMA_ROM_WINDOW);

  // strobe and pending flag
  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      word_wr     <= 1'b0;
      low_pending <= 1'b0;
    end else begin
      word_wr     <= rom_hit || low_pending;
      low_pending <= rom_hit;
    end
  end

  // payload, big endian on the bridge
  always_ff @(posedge clk_32_768) begin
    if (rom_hit) begin
      word_addr <= bridge_addr[13:1];
      word_data <= bridge_wr_data[31:16];
      low_half  <= bridge_wr_data[15:0];
    end else if (low_pending) begin
      // next word, byte address plus two
      word_addr <= word_addr + tama_pkg::rom_addr_t'(1);
      word_data <= low_half;
    end
  end

  // no back-pressure, the host has to leave room for both halves
  rom_write_gap_a : assert property (
    @(posedge clk_32_768) disable iff (reset_turbo_s)
    rom_hit |=> !rom_hit [* (`TAMA_LOADER_GAP - 1)]
  );

endmodule

/* hdl/program_rom.sv */
/*
  Program memory for the CPU. Written from the word loader with the
  bytes swapped, read by the CPU with one cycle of latency. Only the
  low 12 bits of each word reach the fetch port.
*/

`timescale 1ns/10ps

`include "tama_settings.svh"

module program_rom (
  input  logic                  clk_32_768,
  input  logic                  word_wr,
  input  tama_pkg::rom_addr_t   word_addr,
  input  tama_pkg::rom_word_t   word_data,
  input  tama_pkg::rom_addr_t   rom_addr,
  output tama_pkg::fetch_data_t rom_data
);

  tama_pkg::rom_word_t mem [`TAMA_ROM_DEPTH];

  // write port, loader data arrives byte-reversed
  always_ff @(posedge clk_32_768) begin
    if (word_wr) begin
      mem[word_addr] <= {word_data[7:0], word_data[15:8]};
    end
  end

  // fetch port
  always_ff @(posedge clk_32_768) begin
    rom_data <= mem[rom_addr][11:0];
  end

endmodule

/* hdl/buzzer_monitor.sv */
/*
  Turns the CPU buzzer into an audio level and raises the turbo
  cancel pulse on buzzer activity when the host asked for it.
*/

`timescale 1ns/10ps

`include "tama_settings.svh"

module buzzer_monitor (
  input  logic                    clk_32_768,
  input  logic                    reset_turbo_s,
  input  logic                    buzzer,
  input  logic                    disable_sound,
  input  logic                    cancel_on_event,
  output tama_pkg::audio_sample_t audio_l,
  output logic                    cancel_pulse
);

  // full-scale buzzer level
  localparam tama_pkg::audio_sample_t BUZZER_LEVEL =
    tama_pkg::audio_sample_t'({`TAMA_BUZZER_BITS{1'b1}});

  always_ff @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      audio_l      <= '0;
      cancel_pulse <= 1'b0;
    end else begin
      audio_l      <= (buzzer && !disable_sound) ? BUZZER_LEVEL : '0;
      // one pulse per buzzer-high cycle
      cancel_pulse <= buzzer && cancel_on_event;
    end
  end

endmodule

/* hdl/tama_core_top.sv */
/*
  Top level of the handheld-emulation glue logic.
  Connects the settings registers, clock divider, program loader,
  program memory and buzzer monitor. The CPU sits outside.
*/

`timescale 1ns/10ps

module tama_core_top (
  input  logic                    clk_32_768,
  input  logic                    reset_turbo_s,
  input  tama_pkg::bridge_word_t  bridge_addr,
  input  logic                    bridge_wr,
  input  tama_pkg::bridge_word_t  bridge_wr_data,
  input  tama_pkg::rom_addr_t     rom_addr,
  input  logic                    buzzer,
  output tama_pkg::bridge_word_t  bridge_rd_data,
  output tama_pkg::fetch_data_t   rom_data,
  output logic                    clk_en,
  output logic                    clk_2x_en,
  output tama_pkg::audio_sample_t audio_l
);

  // settings
  tama_pkg::turbo_speed_t turbo_speed;
  logic                   disable_sound;
  logic                   cancel_on_event;
  logic                   cancel_pulse;

  // program download path
  logic                   word_wr;
  tama_pkg::rom_addr_t    word_addr;
  tama_pkg::rom_word_t    word_data;

  bridge_settings settings_i (
    .clk_32_768      (clk_32_768),
    .reset_turbo_s   (reset_turbo_s),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .cancel_pulse    (cancel_pulse),
    .bridge_rd_data  (bridge_rd_data),
    .turbo_speed     (turbo_speed),
    .disable_sound   (disable_sound),
    .cancel_on_event (cancel_on_event)
  );

  turbo_clock_divider divider_i (
    .clk_32_768    (clk_32_768),
    .reset_turbo_s (reset_turbo_s),
    .turbo_speed   (turbo_speed),
    .clk_en        (clk_en),
    .clk_2x_en     (clk_2x_en)
  );

  bridge_word_loader loader_i (
    .clk_32_768     (clk_32_768),
    .reset_turbo_s  (reset_turbo_s),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .word_wr        (word_wr),
    .word_addr      (word_addr),
    .word_data      (word_data)
  );

  program_rom rom_i (
    .clk_32_768 (clk_32_768),
    .word_wr    (word_wr),
    .word_addr  (word_addr),
    .word_data  (word_data),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data)
  );

  buzzer_monitor buzzer_i (
    .clk_32_768      (clk_32_768),
    .reset_turbo_s   (reset_turbo_s),
    .buzzer          (buzzer),
    .disable_sound   (disable_sound),
    .cancel_on_event (cancel_on_event),
    .audio_l         (audio_l),
    .cancel_pulse    (cancel_pulse)
  );

endmodule

/* testbench/tama_checker.sv */
/*
  Passive checker for the glue logic testbench. Models the settings,
  audio level and enable timing, compares the DUT outputs on each
  rising edge together with the table's expected values.
*/

`timescale 1ns/10ps

`include "tama_settings.svh"

module tama_checker (
  input  logic                    clk_32_768,
  input  logic                    reset_turbo_s,
  input  tama_pkg::bridge_word_t  bridge_addr,
  input  logic                    bridge_wr,
  input  tama_pkg::bridge_word_t  bridge_wr_data,
  input  logic                    buzzer,
  input  tama_pkg::bridge_word_t  bridge_rd_data,
  input  tama_pkg::fetch_data_t   rom_data,
  input  logic                    clk_en,
  input  logic                    clk_2x_en,
  input  tama_pkg::audio_sample_t audio_l,
  input  logic                    expect_rd_valid,
  input  tama_pkg::bridge_word_t  expect_rd_data,
  input  logic                    expect_fetch_valid,
  input  tama_pkg::fetch_data_t   expect_fetch_data,
  output int                      error_count,
  output int                      check_count,
  output int                      period_count,
  output logic [3:0]              speeds_checked
);

  localparam tama_pkg::audio_sample_t BUZZ_LEVEL = 15'((1 << `TAMA_BUZZER_BITS) - 1);

  logic                    m_sound_off;
  logic                    m_cancel;
  logic                    m_cancel_pulse;
  logic [1:0]              m_speed;
  logic [1:0]              speed_d;
  logic [1:0]              period_speed;
  tama_pkg::audio_sample_t audio_exp;
  logic                    fetch_pending;
  tama_pkg::fetch_data_t   fetch_exp;
  logic                    en_seen;
  int                      since_en;
  int                      halfway_count;

  function automatic int reload_cycles(input logic [1:0] speed);
    case (speed)
      2'd1:    return `TAMA_RELOAD_4X;
      2'd2:    return `TAMA_RELOAD_50X;
      2'd3:    return `TAMA_RELOAD_MAX;
      default: return `TAMA_RELOAD_1X;
    endcase
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      error_count++;
    end
  endtask

  always @(posedge clk_32_768) begin
    if (reset_turbo_s) begin
      m_sound_off    <= 1'b0;
      m_cancel       <= 1'b0;
      m_cancel_pulse <= 1'b0;
      m_speed        <= 2'd0;
      speed_d        <= 2'd0;
      audio_exp      <= '0;
      fetch_pending  <= 1'b0;
      en_seen        <= 1'b0;
      since_en       <= 0;
      halfway_count  <= 0;
      speeds_checked <= '0;
    end else begin
      compare_value("audio_l", 32'(audio_l), 32'(audio_exp));
      compare_value("bridge_rd_data", bridge_rd_data,
                    (bridge_addr == `TAMA_ADDR_TURBO) ? {30'b0, m_speed} : 32'h0);
      if (expect_rd_valid) begin
        compare_value("readback", bridge_rd_data, expect_rd_data);
      end
      // fetch data arrives one cycle after the address
      if (fetch_pending) begin
        compare_value("rom_data", 32'(rom_data), 32'(fetch_exp));
      end
      fetch_pending <= expect_fetch_valid;
      fetch_exp     <= expect_fetch_data;

      //////////////////////////////////////////////////////////////////////
      // enable spacing, period follows the speed seen at the reload
      if (clk_en && !clk_2x_en) begin
        $display("Mismatch at %0t: clk_en pulsed without clk_2x_en", $time);
        error_count++;
      end
      if (clk_en) begin
        if (en_seen) begin
          compare_value("clk_en spacing", 32'(since_en + 1),
                        32'(reload_cycles(period_speed) + 1));
          if (period_speed == speed_d) begin
            compare_value("clk_2x_en per period", 32'(halfway_count + 1), 32'd2);
            speeds_checked[period_speed] <= 1'b1;
          end
          period_count++;
        end
        en_seen       <= 1'b1;
        since_en      <= 0;
        halfway_count <= 0;
        period_speed  <= speed_d;
      end else begin
        since_en <= since_en + 1;
        if (clk_2x_en) begin
          halfway_count <= halfway_count + 1;
        end
      end

      //////////////////////////////////////////////////////////////////////
      // settings and buzzer model
      if (bridge_wr) begin
        case (bridge_addr)
          `TAMA_ADDR_SOUND:  m_sound_off <= bridge_wr_data[0];
          `TAMA_ADDR_TURBO:  m_speed     <= bridge_wr_data[1:0];
          `TAMA_ADDR_CANCEL: m_cancel    <= bridge_wr_data[0];
          default: ;
        endcase
      end
      // cancel beats a host write in the same cycle
      if (m_cancel_pulse) begin
        m_speed <= 2'd0;
      end
      m_cancel_pulse <= buzzer && m_cancel;
      audio_exp      <= (buzzer && !m_sound_off) ? BUZZ_LEVEL : '0;
      speed_d        <= m_speed;
    end
  end

endmodule

/* testbench/tb_tama_core.sv */
/*
  Testbench for the glue logic top level. Builds a table of bridge
  writes, reads, program fetches, buzzer levels and waits, applies it
  on the falling clock edge and lets tama_checker judge the outputs.
*/

`timescale 1ns/10ps

`include "tama_settings.svh"

module tb_tama_core;

  localparam logic [2:0] OP_WRITE = 3'd0;
  localparam logic [2:0] OP_READ  = 3'd1;
  localparam logic [2:0] OP_FETCH = 3'd2;
  localparam logic [2:0] OP_BUZZ  = 3'd3;
  localparam logic [2:0] OP_WAIT  = 3'd4;
  localparam int ROM_WRITES = 6;
  // long enough for two full periods at 1x plus the old period
  localparam int SPEED_WAIT = 3 * (`TAMA_RELOAD_1X + 1) + 100;
  localparam int WATCHDOG_MARGIN = 100;

  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expect_val;
  } entry_t;

  logic                    clk_32_768;
  logic                    reset_turbo_s;
  tama_pkg::bridge_word_t  bridge_addr;
  logic                    bridge_wr;
  tama_pkg::bridge_word_t  bridge_wr_data;
  tama_pkg::rom_addr_t     rom_addr;
  logic                    buzzer;
  tama_pkg::bridge_word_t  bridge_rd_data;
  tama_pkg::fetch_data_t   rom_data;
  logic                    clk_en;
  logic                    clk_2x_en;
  tama_pkg::audio_sample_t audio_l;

  // expected values handed to the checker
  logic                    expect_rd_valid;
  tama_pkg::bridge_word_t  expect_rd_data;
  logic                    expect_fetch_valid;
  tama_pkg::fetch_data_t   expect_fetch_data;
  int                      error_count;
  int                      check_count;
  int                      period_count;
  logic [3:0]              speeds_checked;
  int                      total_errors;

  entry_t      stim_q[$];
  int          table_cycles;
  logic        table_ready;

  tama_core_top dut_i (
    .clk_32_768     (clk_32_768),
    .reset_turbo_s  (reset_turbo_s),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .rom_addr       (rom_addr),
    .buzzer         (buzzer),
    .bridge_rd_data (bridge_rd_data),
    .rom_data       (rom_data),
    .clk_en         (clk_en),
    .clk_2x_en      (clk_2x_en),
    .audio_l        (audio_l)
  );

  tama_checker checker_i (
    .clk_32_768         (clk_32_768),
    .reset_turbo_s      (reset_turbo_s),
    .bridge_addr        (bridge_addr),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .buzzer             (buzzer),
    .bridge_rd_data     (bridge_rd_data),
    .rom_data           (rom_data),
    .clk_en             (clk_en),
    .clk_2x_en          (clk_2x_en),
    .audio_l            (audio_l),
    .expect_rd_valid    (expect_rd_valid),
    .expect_rd_data     (expect_rd_data),
    .expect_fetch_valid (expect_fetch_valid),
    .expect_fetch_data  (expect_fetch_data),
    .error_count        (error_count),
    .check_count        (check_count),
    .period_count       (period_count),
    .speeds_checked     (speeds_checked)
  );

  initial begin
    clk_32_768 = 1'b0;
    forever #5 clk_32_768 = ~clk_32_768;
  end

  // CPU sees the low 12 bits of the byte-swapped half word
  function automatic logic [11:0] fetch_expect(input logic [15:0] half);
    logic [15:0] swapped;
    swapped = {half[7:0], half[15:8]};
    return swapped[11:0];
  endfunction

  task automatic add_entry(input logic [2:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] expect_val);
    stim_q.push_back('{op, addr, data, expect_val});
    table_cycles += (op == OP_WAIT) ? int'(data) : 1;
  endtask

  task automatic build_table();
    logic [31:0] rom_base;
    logic [31:0] rom_addrs [ROM_WRITES];
    logic [31:0] rom_words [ROM_WRITES];
    logic [12:0] word_addr;
    logic [12:0] next_addr;
    // readback after reset, other addresses read zero
    add_entry(OP_READ, `TAMA_ADDR_TURBO, 0, 0);
    add_entry(OP_READ, `TAMA_ADDR_SOUND, 0, 0);
    add_entry(OP_READ, 32'h0000_0200, 0, 0);
    for (int s = 0; s < 4; s++) begin
      add_entry(OP_WRITE, `TAMA_ADDR_TURBO, 32'(s), 0);
      add_entry(OP_READ, `TAMA_ADDR_TURBO, 0, 32'(s));
      add_entry(OP_READ, `TAMA_ADDR_CANCEL, 0, 0);
      add_entry(OP_WAIT, 0, SPEED_WAIT, 0);
    end
    // ROM window downloads, then fetch both halves of each
    rom_base = $urandom & 32'h0000_3f00;
    for (int i = 0; i < ROM_WRITES; i++) begin
      rom_addrs[i] = 32'h1000_0000 | rom_base | 32'(i * 4);
      rom_words[i] = $urandom;
      add_entry(OP_WRITE, rom_addrs[i], rom_words[i], 0);
      add_entry(OP_WAIT, 0, `TAMA_LOADER_GAP - 1, 0);
    end
    add_entry(OP_WAIT, 0, 3, 0);
    for (int i = 0; i < ROM_WRITES; i++) begin
      word_addr = rom_addrs[i][13:1];
      next_addr = word_addr + 13'd1;
      add_entry(OP_FETCH, 32'(word_addr), 0, 32'(fetch_expect(rom_words[i][31:16])));
      add_entry(OP_FETCH, 32'(next_addr), 0, 32'(fetch_expect(rom_words[i][15:0])));
    end
    // buzzer with sound on, then off
    add_entry(OP_BUZZ, 0, 1, 0);
    add_entry(OP_WAIT, 0, 3, 0);
    add_entry(OP_BUZZ, 0, 0, 0);
    add_entry(OP_WRITE, `TAMA_ADDR_SOUND, 1, 0);
    add_entry(OP_BUZZ, 0, 1, 0);
    add_entry(OP_WAIT, 0, 3, 0);
    add_entry(OP_BUZZ, 0, 0, 0);
    add_entry(OP_WRITE, `TAMA_ADDR_SOUND, 0, 0);
    // turbo cancel on, then off
    add_entry(OP_WRITE, `TAMA_ADDR_TURBO, 2, 0);
    add_entry(OP_WRITE, `TAMA_ADDR_CANCEL, 1, 0);
    add_entry(OP_BUZZ, 0, 1, 0);
    add_entry(OP_BUZZ, 0, 0, 0);
    add_entry(OP_WAIT, 0, 1, 0);
    add_entry(OP_READ, `TAMA_ADDR_TURBO, 0, 0);
    add_entry(OP_WRITE, `TAMA_ADDR_CANCEL, 0, 0);
    add_entry(OP_WRITE, `TAMA_ADDR_TURBO, 2, 0);
    add_entry(OP_BUZZ, 0, 1, 0);
    add_entry(OP_BUZZ, 0, 0, 0);
    add_entry(OP_WAIT, 0, 2, 0);
    add_entry(OP_READ, `TAMA_ADDR_TURBO, 0, 2);
    add_entry(OP_WAIT, 0, 20, 0);
  endtask

  task automatic apply_entry(input entry_t e);
    @(negedge clk_32_768);
    bridge_wr          = 1'b0;
    expect_rd_valid    = 1'b0;
    expect_fetch_valid = 1'b0;
    case (e.op)
      OP_WRITE: begin
        bridge_wr      = 1'b1;
        bridge_addr    = e.addr;
        bridge_wr_data = e.data;
      end
      OP_READ: begin
        bridge_addr     = e.addr;
        expect_rd_valid = 1'b1;
        expect_rd_data  = e.expect_val;
      end
      OP_FETCH: begin
        rom_addr           = e.addr[12:0];
        expect_fetch_valid = 1'b1;
        expect_fetch_data  = e.expect_val[11:0];
      end
      OP_BUZZ: buzzer = e.data[0];
      default: repeat (int'(e.data) - 1) @(negedge clk_32_768);
    endcase
  endtask

  initial begin
    reset_turbo_s      = 1'b1;
    bridge_addr        = '0;
    bridge_wr          = 1'b0;
    bridge_wr_data     = '0;
    rom_addr           = '0;
    buzzer             = 1'b0;
    expect_rd_valid    = 1'b0;
    expect_rd_data     = '0;
    expect_fetch_valid = 1'b0;
    expect_fetch_data  = '0;
    table_ready        = 1'b0;
    table_cycles       = 0;
    void'($urandom(32'hdd5677dd));
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk_32_768);
    @(negedge clk_32_768);
    reset_turbo_s = 1'b0;
    foreach (stim_q[i]) apply_entry(stim_q[i]);
    repeat (4) @(negedge clk_32_768);
    total_errors = error_count;
    if (speeds_checked != 4'hf) begin
      $display("Clock enable spacing was not checked at every turbo speed");
      total_errors++;
    end
    $display("Checks: %0d, enable periods: %0d, errors: %0d",
             check_count, period_count, total_errors);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog sized from the stimulus table
  initial begin
    wait (table_ready == 1'b1);
    repeat (table_cycles + 8 + WATCHDOG_MARGIN) @(posedge clk_32_768);
    $display("Timeout: the stimulus table did not complete in time");
    $display("Finished with errors");
    $finish;
  end

endmodule

/* tama_core.f */
+incdir+include
hdl/tama_pkg.sv
hdl/bridge_settings.sv
hdl/turbo_clock_divider.sv
hdl/bridge_word_loader.sv
hdl/program_rom.sv
hdl/buzzer_monitor.sv
hdl/tama_core_top.sv
testbench/tama_checker.sv
testbench/tb_tama_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and sets the exit status from its result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tama_core.f --top-module tb_tama_core \
  && ./obj_dir/Vtb_tama_core | tee /dev/stderr | grep -F "Finished with no errors" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
